// File: logic/armPkg.sv
package armPkg;

    localparam int INSTR_W = 32;

    ////////////////////////////////////////////////////////////////////////////
    // Operation and condition encodings

    // Low 16 codes follow the data-processing opcode field
    typedef enum logic [4:0] {
        AND  = 5'd0,
        EOR  = 5'd1,
        SUB  = 5'd2,
        RSB  = 5'd3,
        ADD  = 5'd4,
        ADC  = 5'd5,
        SBC  = 5'd6,
        RSC  = 5'd7,
        TST  = 5'd8,
        TEQ  = 5'd9,
        CMP  = 5'd10,
        CMN  = 5'd11,
        ORR  = 5'd12,
        MOV  = 5'd13,
        BIC  = 5'd14,
        MVN  = 5'd15,
        MUL  = 5'd16,
        DIV  = 5'd17,
        FADD = 5'd18,
        FMUL = 5'd19
    } aluOpE;

    typedef enum logic [3:0] {
        EQ, NE, CS, CC, MI, PL, VS, VC,
        HI, LS, GE, LT, GT, LE, AL, NV
    } condE;

    ////////////////////////////////////////////////////////////////////////////
    // Payloads

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flagsT;

    typedef struct packed {
        logic [INSTR_W-1:0] instr;
        logic [31:0]        opA;
        logic [31:0]        opB;   // Register operand as read
    } instrInT;

    typedef struct packed {
        condE        cond;
        aluOpE       op;
        logic [3:0]  flagW;     // NZCV order
        logic        regW;
        logic        memW;
        logic        memToReg;
        logic        noWrite;
        logic        pcSrc;
        logic        isBranch;
        logic        isFloat;
        logic [3:0]  rd;
        logic [31:0] opA;
        logic [31:0] opB;       // Operand or extended immediate
    } decodedT;

    typedef struct packed {
        logic [31:0] value;
        logic [3:0]  rd;
        logic        regWrite;
        logic        memWrite;
        logic        pcWrite;
        logic        condPass;
        flagsT       flags;     // Flags after this instruction
    } resultT;

endpackage

// File: logic/creditFifo.sv
`timescale 1ns/1ps

module creditFifo #(
    parameter type payloadT = logic [31:0],
    parameter int  DEPTH    = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  payloadT                    pushData,
    input  logic                       pop,
    output payloadT                    popData,
    output logic                       notEmpty,
    output logic [$clog2(DEPTH+1)-1:0] freeSlots
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payloadT          mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    // Pointers wrap at the last slot
    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    assign popData   = mem[rdPtr];  // Head entry is readable the cycle after push
    assign notEmpty  = (count != '0);
    assign freeSlots = CNT_W'(DEPTH) - count;

    noPushWhenFull: assert property (@(posedge clk) disable iff (rst)
        push |-> (count != CNT_W'(DEPTH)));
    noPopWhenEmpty: assert property (@(posedge clk) disable iff (rst)
        pop |-> notEmpty);

endmodule

// File: logic/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
    input  logic             clk,
    input  logic             rst,
    input  logic             advance,
    input  logic             inValid,
    input  armPkg::instrInT  inData,
    output logic             decValid,
    output armPkg::decodedT  decOp
);
    import armPkg::*;

    logic [INSTR_W-1:0] instr;
    logic [1:0]         opClass;
    logic [5:0]         funct;   // {I, P, U, B, W, L} in the memory class
    aluOpE              dpOp;
    logic               dpLogic;
    decodedT            dec;

    assign instr   = inData.instr;
    assign opClass = instr[27:26];
    assign funct   = instr[25:20];
    assign dpOp    = aluOpE'({1'b0, funct[4:1]});

    // Logical ops leave V alone
    assign dpLogic = dpOp inside {AND, EOR, TST, TEQ, ORR, MOV, BIC, MVN};

    ////////////////////////////////////////////////////////////////////////////
    // Field decode

    always_comb begin
        dec      = '0;
        dec.cond = condE'(instr[31:28]);
        dec.rd   = instr[15:12];
        dec.opA  = inData.opA;
        dec.opB  = inData.opB;
        dec.op   = ADD;

        case (opClass)
            2'b00: begin
                if (!funct[5] && instr[7:4] == 4'b1001 && instr[24:21] == 4'b0000) begin
                    dec.op = MUL;                   // No flags and no register write
                end else begin
                    dec.op      = dpOp;
                    dec.regW    = 1'b1;
                    dec.noWrite = dpOp inside {TST, TEQ, CMP, CMN};
                    if (funct[0]) begin
                        dec.flagW = dpLogic ? 4'b1110 : 4'b1111;
                    end
                    if (funct[5]) begin
                        dec.opB = {24'b0, instr[7:0]};
                    end
                end
            end

            2'b01: begin
                if (funct == 6'b111111 && instr[7:4] == 4'b1111) begin
                    dec.op = DIV;
                end else begin
                    dec.op       = funct[3] ? ADD : SUB;   // U bit
                    dec.memW     = !funct[0];
                    dec.memToReg = funct[0];
                    dec.regW     = funct[0];               // LDR only
                    if (!funct[5]) begin
                        dec.opB = {20'b0, instr[11:0]};
                    end
                end
            end

            2'b10: begin
                dec.isBranch = 1'b1;
                dec.opB      = {{6{instr[23]}}, instr[23:0], 2'b00};   // Word offset
            end

            default: begin
                // Only the float-add pattern is recognized
                if (funct ==? 6'b100?11) begin
                    dec.isFloat = 1'b1;
                    dec.op      = FADD;
                end
            end
        endcase

        dec.pcSrc = (dec.rd == 4'd15 && dec.regW) || dec.isBranch;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage register

    always_ff @(posedge clk) begin
        if (rst) begin
            decValid <= 1'b0;
        end else if (advance) begin
            decValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && inValid) begin
            decOp <= dec;
        end
    end

endmodule

// File: logic/aluExecute.sv
`timescale 1ns/1ps

module aluExecute (
    input  logic             clk,
    input  logic             rst,
    input  logic             advance,
    input  logic             decValid,
    input  armPkg::decodedT  decOp,
    output logic             exValid,
    output armPkg::resultT   exRes
);
    import armPkg::*;

    flagsT       flags;
    flagsT       flagsNext;
    logic        condPass;
    logic [31:0] x;
    logic [31:0] y;
    logic        cin;
    logic [32:0] sum;
    logic [31:0] value;
    logic        carry;

    always_comb begin
        case (decOp.cond)
            EQ: condPass = flags.z;
            NE: condPass = !flags.z;
            CS: condPass = flags.c;
            CC: condPass = !flags.c;
            MI: condPass = flags.n;
            PL: condPass = !flags.n;
            VS: condPass = flags.v;
            VC: condPass = !flags.v;
            HI: condPass = flags.c && !flags.z;
            LS: condPass = !flags.c || flags.z;
            GE: condPass = (flags.n == flags.v);
            LT: condPass = (flags.n != flags.v);
            GT: condPass = !flags.z && (flags.n == flags.v);
            LE: condPass = flags.z || (flags.n != flags.v);
            AL: condPass = 1'b1;
            default: condPass = 1'b0;   // NV never executes
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Adder operands with subtraction as inverted operand plus carry in

    always_comb begin
        x   = decOp.opA;
        y   = decOp.opB;
        cin = 1'b0;
        case (decOp.op)
            SUB, CMP: begin
                y   = ~decOp.opB;
                cin = 1'b1;
            end
            RSB: begin
                x   = ~decOp.opA;
                cin = 1'b1;
            end
            ADC: cin = flags.c;
            SBC: begin
                y   = ~decOp.opB;
                cin = flags.c;
            end
            RSC: begin
                x   = ~decOp.opA;
                cin = flags.c;
            end
            default: ;
        endcase
    end

    assign sum = {1'b0, x} + {1'b0, y} + {32'b0, cin};

    always_comb begin
        carry = sum[32];
        case (decOp.op)
            AND, TST:   value = decOp.opA & decOp.opB;
            EOR, TEQ:   value = decOp.opA ^ decOp.opB;
            ORR:        value = decOp.opA | decOp.opB;
            MOV:        value = decOp.opB;
            BIC:        value = decOp.opA & ~decOp.opB;
            MVN:        value = ~decOp.opB;
            MUL:        value = decOp.opA * decOp.opB;   // Low word
            DIV:        value = (decOp.opB == '0) ? '1 : decOp.opA / decOp.opB;
            FADD, FMUL: value = '0;
            default:    value = sum[31:0];
        endcase
        if (decOp.op inside {AND, EOR, TST, TEQ, ORR, MOV, BIC, MVN}) begin
            carry = flags.c;    // Logical ops pass the old C through
        end
    end

    // Masked flag update that holds on a failed condition
    always_comb begin
        flagsNext = flags;
        if (condPass) begin
            if (decOp.flagW[3]) flagsNext.n = value[31];
            if (decOp.flagW[2]) flagsNext.z = (value == '0);
            if (decOp.flagW[1]) flagsNext.c = carry;
            if (decOp.flagW[0]) flagsNext.v = (x[31] == y[31]) && (sum[31] != x[31]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exValid <= 1'b0;
            flags   <= '0;
        end else if (advance) begin
            exValid <= decValid;
            if (decValid) begin
                flags <= flagsNext;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance && decValid) begin
            exRes.value    <= value;
            exRes.rd       <= decOp.rd;
            exRes.regWrite <= condPass && decOp.regW && !decOp.noWrite;
            exRes.memWrite <= condPass && decOp.memW;
            exRes.pcWrite  <= condPass && decOp.pcSrc;
            exRes.condPass <= condPass;
            exRes.flags    <= flagsNext;
        end
    end

    decOpKnown: assert property (@(posedge clk) disable iff (rst)
        decValid |-> !$isunknown(decOp));

endmodule

// File: logic/resultStage.sv
`timescale 1ns/1ps

module resultStage #(
    parameter int OUT_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            exValid,
    input  armPkg::resultT  exRes,
    input  logic            decValid,
    input  logic            outCredit,
    output logic            advance,
    output logic            outValid,
    output armPkg::resultT  outData
);
    import armPkg::*;

    localparam int CNT_W = $clog2(OUT_DEPTH + 1);

    logic [CNT_W-1:0] freeSlots;
    logic [CNT_W-1:0] stageCnt;
    logic [CNT_W-1:0] creditCnt;
    logic             notEmpty;
    logic             push;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline advance

    // Everything still in flight must fit in the buffer
    assign stageCnt = CNT_W'(decValid) + CNT_W'(exValid);
    assign advance  = (freeSlots >= stageCnt);
    assign push     = exValid && advance;

    creditFifo #(
        .payloadT (resultT),
        .DEPTH    (OUT_DEPTH)
    ) outBuf_i (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .pushData  (exRes),
        .pop       (outValid),
        .popData   (outData),
        .notEmpty  (notEmpty),
        .freeSlots (freeSlots)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Output credits

    assign outValid = notEmpty && (creditCnt != '0);   // One record per cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            creditCnt <= CNT_W'(OUT_DEPTH);
        end else begin
            creditCnt <= creditCnt - CNT_W'(outValid) + CNT_W'(outCredit);
        end
    end

    // Sink may never return more than it was given
    creditBound: assert property (@(posedge clk) disable iff (rst)
        creditCnt <= CNT_W'(OUT_DEPTH));

endmodule

// File: logic/armExecCore.sv
`timescale 1ns/1ps

module armExecCore #(
    parameter int IN_DEPTH  = 4,
    parameter int OUT_DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             inValid,
    input  armPkg::instrInT  inData,
    output logic             inCredit,
    output logic             outValid,
    output armPkg::resultT   outData,
    input  logic             outCredit
);
    import armPkg::*;

    instrInT bufData;
    logic    bufValid;
    logic    bufPop;
    logic    advance;
    logic    decValid;
    decodedT decOp;
    logic    exValid;
    resultT  exRes;

    assign bufPop   = advance && bufValid;
    assign inCredit = bufPop;   // Each freed slot returns a credit to the source

    creditFifo #(
        .payloadT (instrInT),
        .DEPTH    (IN_DEPTH)
    ) inBuf_i (
        .clk       (clk),
        .rst       (rst),
        .push      (inValid),
        .pushData  (inData),
        .pop       (bufPop),
        .popData   (bufData),
        .notEmpty  (bufValid),
        .freeSlots ()
    );

    instrDecoder decoder_i (
        .clk(clk), .rst(rst), .advance(advance),
        .inValid(bufValid), .inData(bufData),
        .decValid(decValid), .decOp(decOp)
    );

    aluExecute execute_i (
        .clk(clk), .rst(rst), .advance(advance),
        .decValid(decValid), .decOp(decOp),
        .exValid(exValid), .exRes(exRes)
    );

    resultStage #(.OUT_DEPTH(OUT_DEPTH)) result_i (
        .clk(clk), .rst(rst), .exValid(exValid), .exRes(exRes),
        .decValid(decValid), .outCredit(outCredit), .advance(advance),
        .outValid(outValid), .outData(outData)
    );

endmodule

// File: sim/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release 1 ns after the last reset edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// File: sim/armExecCoreTb.sv
`timescale 1ns/1ps

module armExecCoreTb;
    import armPkg::*;

    localparam int IN_DEPTH  = 4;
    localparam int OUT_DEPTH = 4;
    localparam int NUM_INSTR = 400;
    localparam int TIMEOUT   = NUM_INSTR * 20;

    logic    clk;
    logic    rst;
    logic    inValid;
    instrInT inData;
    logic    inCredit;
    logic    outValid;
    resultT  outData;
    logic    outCredit;

    integer  seed;
    flagsT   modelFlags;
    resultT  expQ[$];
    int      releaseAt[$];   // Cycle at which each held output credit goes back
    int      srcCredits;
    int      sent;
    int      received;
    int      creditsBack;
    int      cycle;

    tbClock #(.PERIOD(4), .RESET_CYCLES(4)) clock_i (
        .clk (clk),
        .rst (rst)
    );

    armExecCore #(
        .IN_DEPTH  (IN_DEPTH),
        .OUT_DEPTH (OUT_DEPTH)
    ) dut_i (
        .clk       (clk),
        .rst       (rst),
        .inValid   (inValid),
        .inData    (inData),
        .inCredit  (inCredit),
        .outValid  (outValid),
        .outData   (outData),
        .outCredit (outCredit)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference model

    function automatic logic condHolds(input logic [3:0] code, input flagsT f);
        case (condE'(code))
            EQ: return f.z;
            NE: return !f.z;
            CS: return f.c;
            CC: return !f.c;
            MI: return f.n;
            PL: return !f.n;
            VS: return f.v;
            VC: return !f.v;
            HI: return f.c && !f.z;
            LS: return !f.c || f.z;
            GE: return f.n == f.v;
            LT: return f.n != f.v;
            GT: return !f.z && (f.n == f.v);
            LE: return f.z || (f.n != f.v);
            AL: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Returns {carry, overflow, sum}
    function automatic logic [33:0] addCarry(input logic [31:0] x, input logic [31:0] y,
                                             input logic cin);
        logic [32:0] s;
        logic        ovf;
        s   = {1'b0, x} + {1'b0, y} + {32'b0, cin};
        ovf = (x[31] == y[31]) && (s[31] != x[31]);
        return {s[32], ovf, s[31:0]};
    endfunction

    task automatic modelExec(input instrInT item, output resultT exp);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] off;
        logic [33:0] r;
        logic [3:0]  mask;
        logic        pass;
        logic        regW;
        logic        memW;
        logic        pcW;
        aluOpE       op;
        flagsT       nf;
        w    = item.instr;
        a    = item.opA;
        b    = item.opB;
        r    = {modelFlags.c, modelFlags.v, 32'b0};   // Logical ops keep C and V
        mask = 4'b0000;
        regW = 1'b0;
        memW = 1'b0;
        pcW  = 1'b0;
        pass = condHolds(w[31:28], modelFlags);
        op   = aluOpE'({1'b0, w[24:21]});
        case (w[27:26])
            2'b00: begin
                if (!w[25] && w[7:4] == 4'b1001 && op == AND) begin
                    r[31:0] = a * b;
                end else begin
                    if (w[25]) b = {24'b0, w[7:0]};
                    case (op)
                        AND, TST: r[31:0] = a & b;
                        EOR, TEQ: r[31:0] = a ^ b;
                        SUB, CMP: r = addCarry(a, ~b, 1'b1);
                        RSB:      r = addCarry(b, ~a, 1'b1);
                        ADD, CMN: r = addCarry(a, b, 1'b0);
                        ADC:      r = addCarry(a, b, modelFlags.c);
                        SBC:      r = addCarry(a, ~b, modelFlags.c);
                        RSC:      r = addCarry(b, ~a, modelFlags.c);
                        ORR:      r[31:0] = a | b;
                        MOV:      r[31:0] = b;
                        BIC:      r[31:0] = a & ~b;
                        default:  r[31:0] = ~b;   // MVN
                    endcase
                    regW = !(op inside {TST, TEQ, CMP, CMN});
                    pcW  = regW && (w[15:12] == 4'd15);
                    if (w[20]) begin
                        mask = (op inside {AND, EOR, TST, TEQ, ORR, MOV, BIC, MVN}) ?
                               4'b1110 : 4'b1111;
                    end
                end
            end
            2'b01: begin
                if (w[25:20] == 6'b111111 && w[7:4] == 4'b1111) begin
                    r[31:0] = (b == 32'd0) ? 32'hFFFF_FFFF : a / b;
                end else begin
                    off     = w[25] ? b : {20'b0, w[11:0]};
                    r[31:0] = w[23] ? a + off : a - off;
                    memW    = !w[20];
                    regW    = w[20];
                    pcW     = w[20] && (w[15:12] == 4'd15);
                end
            end
            2'b10: begin
                r[31:0] = a + {{6{w[23]}}, w[23:0], 2'b00};
                pcW     = 1'b1;
            end
            default: r[31:0] = 32'd0;   // Float passes through
        endcase

        nf = modelFlags;
        if (pass) begin
            if (mask[3]) nf.n = r[31];
            if (mask[2]) nf.z = (r[31:0] == 32'd0);
            if (mask[1]) nf.c = r[33];
            if (mask[0]) nf.v = r[32];
        end
        modelFlags = nf;

        exp.value    = r[31:0];
        exp.rd       = w[15:12];
        exp.regWrite = pass && regW;
        exp.memWrite = pass && memW;
        exp.pcWrite  = pass && pcW;
        exp.condPass = pass;
        exp.flags    = nf;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    function automatic logic [31:0] randOperand();
        case ({$random(seed)} % 5)
            0: return 32'd0;
            1: return 32'({$random(seed)} % 8);
            2: return 32'h7FFF_FFFF;
            3: return 32'hFFFF_FFFF - 32'({$random(seed)} % 4);
            default: return $random(seed);
        endcase
    endfunction

    task automatic makeInstr(output instrInT item);
        logic [31:0] w;
        int          kind;
        aluOpE       op;
        w    = $random(seed);
        kind = int'({$random(seed)} % 12);
        case (kind)
            0, 1, 2, 3, 4: begin
                w[27:26] = 2'b00;
                op = aluOpE'({1'b0, w[24:21]});
                if (op inside {TST, TEQ, CMP, CMN}) begin
                    w[20]    = 1'b1;   // Compares always set flags
                    w[15:12] = 4'd0;
                end
                if (!w[25]) w[11:4] = 8'd0;   // Plain register operand
            end
            5: begin
                w[27:20] = 8'd0;
                w[7:4]   = 4'b1001;
            end
            6, 7: begin
                w[27:26] = 2'b01;
                w[22]    = 1'b0;   // Word access
                if (w[25]) w[11:4] = 8'd0;
            end
            8: begin
                w[27:20] = 8'b0111_1111;
                w[7:4]   = 4'b1111;
            end
            9, 10: w[27:25] = 3'b101;
            default: w[27:20] = {2'b11, 3'b100, w[22], 2'b11};
        endcase
        w[31:28] = ($random(seed) & 1) ? 4'hE : 4'($random(seed));
        item.instr = w;
        item.opA   = randOperand();
        item.opB   = randOperand();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks

    task automatic failNow();
        $display("Test failures found");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic checkResult(input resultT got, input resultT exp, input int idx);
        if (got !== exp) begin
            $display("error %0t ns: result %0d is value %h rd %0d wr/mem/pc/cond %b%b%b%b",
                     $time, idx, got.value, got.rd, got.regWrite, got.memWrite,
                     got.pcWrite, got.condPass);
            $display("    expected value %h rd %0d wr/mem/pc/cond %b%b%b%b",
                     exp.value, exp.rd, exp.regWrite, exp.memWrite, exp.pcWrite,
                     exp.condPass);
            failNow();
        end
    endtask

    task automatic checkFlags(input flagsT got, input flagsT exp, input int idx);
        if (got !== exp) begin
            $display("error %0t ns: flags after instruction %0d are NZCV %b, expected %b",
                     $time, idx, got, exp);
            failNow();
        end
    endtask

    initial begin
        instrInT item;
        resultT  exp;
        resultT  head;
        int      delay;
        inValid     = 1'b0;
        inData      = '0;
        outCredit   = 1'b0;
        seed        = 91;
        modelFlags  = '0;
        srcCredits  = IN_DEPTH;
        sent        = 0;
        received    = 0;
        creditsBack = 0;
        cycle       = 0;

        @(posedge clk);
        while (rst) @(posedge clk);

        while (received < NUM_INSTR) begin
            #1;
            inValid   = 1'b0;
            outCredit = 1'b0;
            if (sent < NUM_INSTR && srcCredits > 0 && ($random(seed) & 3) != 0) begin
                makeInstr(item);
                modelExec(item, exp);
                expQ.push_back(exp);
                inData  = item;
                inValid = 1'b1;
                srcCredits--;
                sent++;
            end
            if (releaseAt.size() > 0 && releaseAt[0] <= cycle) begin
                outCredit = 1'b1;
                void'(releaseAt.pop_front());
            end

            @(negedge clk);
            if (inCredit) begin
                srcCredits++;
                creditsBack++;
            end
            if (srcCredits > IN_DEPTH) begin
                $display("More input credits came back than instructions were sent");
                failNow();
            end
            if (outValid) begin
                if (expQ.size() == 0) begin
                    $display("An output record arrived with no instruction outstanding");
                    failNow();
                end
                head = expQ.pop_front();
                checkFlags(outData.flags, head.flags, received);
                checkResult(outData, head, received);
                received++;
                // Slow sink phases build back-pressure
                delay = ((cycle / 256) % 2 == 1) ? int'({$random(seed)} % 16) :
                                                   int'({$random(seed)} % 2);
                releaseAt.push_back(cycle + 1 + delay);
                if (releaseAt.size() > OUT_DEPTH) begin
                    $display("More than %0d output records are outstanding", OUT_DEPTH);
                    failNow();
                end
            end

            @(posedge clk);
            cycle++;
            if (cycle >= TIMEOUT) begin
                $display("Timeout after %0d cycles with %0d of %0d results received",
                         cycle, received, NUM_INSTR);
                failNow();
            end
        end

        // Quiet window that catches extra records or credits
        #1;
        inValid   = 1'b0;
        outCredit = 1'b0;
        repeat (8) begin
            @(negedge clk);
            if (inCredit) begin
                creditsBack++;
            end
            if (outValid) begin
                $display("An output record arrived after the last expected result");
                failNow();
            end
        end

        checkFlags(dut_i.execute_i.flags, modelFlags, NUM_INSTR);   // Final flag register
        if (creditsBack != sent) begin
            $display("Input credits returned %0d for %0d instructions sent", creditsBack, sent);
            failNow();
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

// File: files.f
logic/armPkg.sv
logic/creditFifo.sv
logic/instrDecoder.sv
logic/aluExecute.sv
logic/resultStage.sv
logic/armExecCore.sv
sim/tbClock.sv
sim/armExecCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module armExecCoreTb \
    --Mdir obj_dir -o armExecCoreTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/armExecCoreTb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0
